/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= int_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/int_asserts.sv */
module int_asserts (
   input logic        clk,
   input logic        rst_n,
   input logic        busy,
   input logic        decode_start_int,
   input logic        decode_end_int,
   input logic        flush,
   input logic        mem_valid,
   input logic        mem_ready,
   input logic [31:0] mem_address,
   input logic        mem_wr_en,
   input logic [31:0] mem_wr_data,
   input logic        fetch_load,
   input logic        reg_load_cs,
   input logic        int_clear
);

   int   fail_count = 0;
   logic any_ctrl;

   assign any_ctrl = decode_start_int | flush | mem_valid | mem_wr_en | fetch_load
                     | reg_load_cs | int_clear;

   // ########################################
   // Reset and idle
   // ########################################

   quiet_when_idle: assert property (@(posedge clk) (!rst_n || !busy) |-> !any_ctrl)
      else begin
         $error("control output high while idle or in reset");
         fail_count = fail_count + 1;
      end

   // ########################################
   // Drain, memory request and redirect
   // ########################################

   drain_holds: assert property (@(posedge clk) disable iff (!rst_n)
      decode_start_int && !decode_end_int |=> decode_start_int)
      else begin
         $error("decode_start_int dropped before decode_end_int");
         fail_count = fail_count + 1;
      end

   flush_after_drain: assert property (@(posedge clk) disable iff (!rst_n)
      decode_start_int && decode_end_int |=> flush)
      else begin
         $error("flush missing one cycle after decode_end_int");
         fail_count = fail_count + 1;
      end

   flush_only_after_drain: assert property (@(posedge clk) disable iff (!rst_n)
      flush |-> $past(decode_start_int && decode_end_int))
      else begin
         $error("flush without a drained decode");
         fail_count = fail_count + 1;
      end

   // The held request may not move while memory stalls.
   request_held: assert property (@(posedge clk) disable iff (!rst_n)
      mem_valid && !mem_ready |=> mem_valid && $stable(mem_address) && $stable(mem_wr_en)
                                  && $stable(mem_wr_data))
      else begin
         $error("memory request changed before mem_ready");
         fail_count = fail_count + 1;
      end

   redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      (fetch_load || int_clear) |-> (fetch_load && int_clear) ##1 !(fetch_load || int_clear))
      else begin
         $error("fetch_load and int_clear not a single shared cycle");
         fail_count = fail_count + 1;
      end

   // The selector is loaded in the cycle just before fetch is redirected.
   selector_before_redirect: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_load |-> $past(reg_load_cs))
      else begin
         $error("fetch_load without reg_load_cs in the cycle before");
         fail_count = fail_count + 1;
      end

endmodule

/* dv/int_tb.sv */
`include "int_macros.svh"

module int_tb;

   localparam int CLK_PERIOD = 8;
   localparam int NUM_TESTS  = 5;
   localparam int MAX_INTS   = 3;    // Most interrupts taken by one test.
   localparam int INT_CYCLES = 150;  // Worst case for one interrupt under the longest stalls.

   logic                  clk = 1'b0;
   logic                  rst_n = 1'b0;
   logic [`INT_LINES-1:0] irq = '0;
   logic [`INT_LINES-1:0] int_mask = '0;
   logic [31:0]           current_eip = '0;
   logic                  decode_end_int = 1'b0;
   logic                  mem_ready = 1'b0;
   logic                  mem_dp_valid = 1'b0;
   logic [31:0]           mem_dp_read_data = '0;
   logic                  decode_start_int, flush, mem_valid, mem_wr_en;
   logic                  fetch_load, reg_load_cs, int_clear;
   logic [31:0]           mem_address, mem_wr_data, fetch_load_address;
   logic [15:0]           reg_cs;

   logic [31:0] mem [0:4095];
   int unsigned max_ready_delay = 3;
   int unsigned max_decode_delay = 5;
   int unsigned ready_cnt = 0;
   int unsigned dec_cnt = 0;
   int          rd_cnt = 0;
   logic        req_seen = 1'b0;
   logic [31:0] rd_addr = '0;

   int          exp_vecs[$];  // Vectors in the order they should be served.
   logic [31:0] exp_sp = `STACK_TOP;
   logic [31:0] flush_eip = '0;
   logic        hi_next = 1'b0;
   string       test_name = "none";
   int          errors = 0;
   int          tests_failed = 0;
   int          test_start = 0;

   int_unit_top dut_i (.*);

   bind int_unit_top int_asserts asserts_i (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [31:0] fill_word(input logic [31:0] addr);
      return (addr * 32'h9e37_79b1) ^ 32'h0f0f_5a5a;
   endfunction

   function automatic int total_errors();
      return errors + dut_i.asserts_i.fail_count;
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("CHECK FAILED %s, %s: expected %h, actual %h", test_name, what,
                  expected, actual);
         errors++;
      end
   endtask

   // ########################################
   // Decode, EIP and memory models
   // ########################################

   always @(posedge clk) begin
      current_eip  <= $urandom;
      mem_dp_valid <= 1'b0;
      if (!decode_start_int) begin
         decode_end_int <= 1'b0;
         dec_cnt        <= $urandom_range(max_decode_delay);
      end else if (dec_cnt == 0) begin
         decode_end_int <= 1'b1;
      end else begin
         dec_cnt <= dec_cnt - 1;
      end
      if (mem_valid && mem_ready) begin
         mem_ready <= 1'b0;
         req_seen  <= 1'b0;
         if (mem_wr_en) begin
            mem[mem_address[13:2]] <= mem_wr_data;
         end else begin
            rd_addr <= mem_address;
            rd_cnt  <= 1 + int'($urandom_range(2));
         end
      end else if (mem_valid && !req_seen) begin
         req_seen  <= 1'b1;
         ready_cnt <= $urandom_range(max_ready_delay);
      end else if (mem_valid && ready_cnt == 0) begin
         mem_ready <= 1'b1;
      end else if (mem_valid) begin
         ready_cnt <= ready_cnt - 1;
      end
      if (rd_cnt == 1) begin
         mem_dp_valid     <= 1'b1;
         mem_dp_read_data <= mem[rd_addr[13:2]];
      end
      if (rd_cnt > 0) begin
         rd_cnt <= rd_cnt - 1;
      end
   end

   // Expected traffic comes from the stack rule and the vector being served.
   always @(posedge clk) begin : monitor
      logic [31:0] entry;
      logic [31:0] sel_word;
      entry = `IDT_BASE;
      if (exp_vecs.size() != 0) begin
         entry = `IDT_BASE + 32'(exp_vecs[0]) * 32'd8;
      end
      sel_word = fill_word(entry + `WORD_BYTES);
      if (flush) begin
         flush_eip = current_eip;
      end
      if (mem_valid && mem_ready) begin
         if (mem_wr_en) begin
            check_value("push address", exp_sp - `WORD_BYTES, mem_address);
            check_value("push data", flush_eip, mem_wr_data);
            exp_sp = exp_sp - `WORD_BYTES;
         end else if (!hi_next) begin
            check_value("offset read address", entry, mem_address);
            hi_next = 1'b1;
         end else begin
            check_value("selector read address", entry + `WORD_BYTES, mem_address);
            hi_next = 1'b0;
         end
      end
      if (fetch_load && exp_vecs.size() == 0) begin
         $display("Test %s: fetch redirect with no interrupt expected", test_name);
         errors++;
      end else if (fetch_load) begin
         check_value("new EIP", fill_word(entry), fetch_load_address);
         check_value("new CS", {16'h0, sel_word[15:0]}, {16'h0, reg_cs});
         void'(exp_vecs.pop_front());
      end
   end

   task automatic start_test(input string name);
      test_name  = name;
      test_start = total_errors();
   endtask

   task automatic end_test();
      repeat (2) @(negedge clk);  // The last redirect and the cycle after it are checked first.
      $display("Test %s finished with %0d errors", test_name, total_errors() - test_start);
      if (total_errors() != test_start) begin
         tests_failed++;
      end
   endtask

   task automatic raise_lines(input logic [`INT_LINES-1:0] lines);
      @(posedge clk);
      irq <= lines;
      @(posedge clk);
      irq <= '0;
   endtask

   task automatic wait_redirect();
      int n;
      n = 0;
      @(posedge clk);
      while (!fetch_load && n < INT_CYCLES) begin
         @(posedge clk);
         n++;
      end
      if (!fetch_load) begin
         $display("Test %s: no fetch redirect within %0d cycles", test_name, INT_CYCLES);
         errors++;
      end
   endtask

   task automatic take_one(input int line);
      exp_vecs.push_back(line);
      raise_lines(`INT_LINES'(1 << line));
      wait_redirect();
   endtask

   // ########################################
   // Tests
   // ########################################

   initial begin
      void'($urandom(32'h8c27));
      for (int i = 0; i < 4096; i++) begin
         mem[i[11:0]] = fill_word(32'(i) << 2);
      end
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      start_test("reset_idle");
      repeat (12) begin
         @(posedge clk);
         assert (!(decode_start_int || flush || mem_valid || mem_wr_en || fetch_load
                   || reg_load_cs || int_clear)) else begin
            $display("Test %s: a control output rose with no interrupt pending", test_name);
            errors++;
         end
      end
      end_test();

      start_test("drain_wait");
      max_decode_delay = 20;  // Decode takes a long time to empty.
      take_one(3);
      max_decode_delay = 5;
      end_test();

      start_test("stack_walk");
      take_one(0);
      take_one(7);
      take_one(4);
      end_test();

      start_test("priority_mask");
      @(posedge clk);
      int_mask <= 8'h04;  // Line 2 waits behind the mask.
      exp_vecs.push_back(5);
      exp_vecs.push_back(6);
      exp_vecs.push_back(2);
      raise_lines(8'h64);
      wait_redirect();
      wait_redirect();
      int_mask <= 8'h00;
      wait_redirect();
      end_test();

      start_test("backpressure");
      max_ready_delay = 12;
      exp_vecs.push_back(1);
      exp_vecs.push_back(3);
      raise_lines(8'h0a);
      wait_redirect();
      wait_redirect();
      take_one(6);
      max_ready_delay = 3;
      end_test();

      $display("Tests run: %0d, failed: %0d, errors: %0d", NUM_TESTS, tests_failed,
               total_errors());
      if (total_errors() == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(CLK_PERIOD * (NUM_TESTS * MAX_INTS * INT_CYCLES + 50));
      $display("Watchdog expired before the tests finished");
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

/* files.f */
+incdir+hdl
hdl/int_pkg.sv
hdl/int_vector_select.sv
hdl/int_sequencer.sv
hdl/int_mem_port.sv
hdl/int_target_capture.sv
hdl/int_unit_top.sv
dv/int_asserts.sv
dv/int_tb.sv

/* hdl/int_macros.svh */
`ifndef INT_MACROS_SVH
`define INT_MACROS_SVH

// Number of interrupt request lines and the width of a vector number.
`define INT_LINES 8
`define INT_VEC_W 3

// Descriptor table lives at a fixed byte address.
// Each entry holds two words, the offset first and the selector second.
`define IDT_BASE 32'h0000_1000

// The stack grows down from here.
`define STACK_TOP 32'h0000_2000

// Stack step, and the selector offset within an entry.
`define WORD_BYTES 32'd4

`endif

/* hdl/int_mem_port.sv */
`include "int_macros.svh"

module int_mem_port
   import int_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  mem_op_e               mem_op,
   input  logic [`INT_VEC_W-1:0] vector,
   input  logic [31:0]           return_eip,
   input  logic                  mem_ready,
   output logic                  mem_valid,
   output logic [31:0]           mem_address,
   output logic                  mem_wr_en,
   output logic [31:0]           mem_wr_data
);

   logic [31:0] stack_ptr;
   logic [31:0] push_addr;
   logic [31:0] entry_addr;
   logic [31:0] next_addr;
   logic        issue;
   logic        accept;

   assign push_addr  = stack_ptr - `WORD_BYTES;  // Pre-decrement push.
   assign entry_addr = `IDT_BASE + {{(32 - `INT_VEC_W - 3){1'b0}}, vector, 3'b000};

   // A new request starts only when none is outstanding.
   assign issue  = !mem_valid && (mem_op != NONE);
   assign accept = mem_valid && mem_ready;

   always_comb begin
      case (mem_op)
         PUSH_EIP: next_addr = push_addr;
         IDT_LO:   next_addr = entry_addr;
         IDT_HI:   next_addr = entry_addr + `WORD_BYTES;
         default:  next_addr = push_addr;
      endcase
   end

   // ########################################
   // Request control and stack pointer
   // ########################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_valid <= 1'b0;
         mem_wr_en <= 1'b0;
         stack_ptr <= `STACK_TOP;
      end else if (accept) begin
         mem_valid <= 1'b0;
         mem_wr_en <= 1'b0;
         if (mem_wr_en) begin
            stack_ptr <= push_addr;  // The push has landed.
         end
      end else if (issue) begin
         mem_valid <= 1'b1;
         mem_wr_en <= (mem_op == PUSH_EIP);
      end
   end

   // Address and data are loaded once per request and held until accepted.
   always_ff @(posedge clk) begin
      if (issue) begin
         mem_address <= next_addr;
         mem_wr_data <= return_eip;
      end
   end

endmodule

/* hdl/int_pkg.sv */
package int_pkg;

   // ########################################
   // Sequencer states
   // ########################################

   // One pass through the list takes a single interrupt from drain to fetch redirect.
   typedef enum logic [3:0] {
      IDLE    = 4'd0,
      DRAIN   = 4'd1,   // Decode is told to stop and empty out.
      FLUSH   = 4'd2,
      PUSH    = 4'd3,
      READ_LO = 4'd4,
      WAIT_LO = 4'd5,
      READ_HI = 4'd6,
      WAIT_HI = 4'd7,
      LOAD    = 4'd8
   } int_state_e;

   // ########################################
   // Memory operations
   // ########################################

   typedef enum logic [1:0] {
      NONE     = 2'd0,
      PUSH_EIP = 2'd1,  // Write of the return EIP below the stack pointer.
      IDT_LO   = 2'd2,  // Offset word of the descriptor entry.
      IDT_HI   = 2'd3   // Selector word.
   } mem_op_e;

endpackage

/* hdl/int_sequencer.sv */
module int_sequencer
   import int_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    or_int_vec,
   input  logic    decode_end_int,
   input  logic    mem_ready,
   input  logic    mem_dp_valid,
   output logic    busy,
   output logic    decode_start_int,
   output logic    flush,
   output logic    capture_bottom_eip,
   output mem_op_e mem_op,
   output logic    load_eip,
   output logic    reg_load_cs,
   output logic    fetch_load,
   output logic    int_clear
);

   int_state_e state;
   int_state_e state_next;

   // ########################################
   // State register and next state
   // ########################################

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            if (or_int_vec) begin
               state_next = DRAIN;
            end
         end
         DRAIN: begin
            if (decode_end_int) begin
               state_next = FLUSH;
            end
         end
         FLUSH:   state_next = PUSH;
         PUSH: begin
            if (mem_ready) begin  // Request states move on acceptance.
               state_next = READ_LO;
            end
         end
         READ_LO: begin
            if (mem_ready) begin
               state_next = WAIT_LO;
            end
         end
         WAIT_LO: begin
            if (mem_dp_valid) begin  // Wait states move on returned data.
               state_next = READ_HI;
            end
         end
         READ_HI: begin
            if (mem_ready) begin
               state_next = WAIT_HI;
            end
         end
         WAIT_HI: begin
            if (mem_dp_valid) begin
               state_next = LOAD;
            end
         end
         LOAD:    state_next = IDLE;
         default: state_next = IDLE;
      endcase
   end

   // ########################################
   // Output decode
   // ########################################

   always_comb begin
      case (state)
         PUSH:    mem_op = PUSH_EIP;
         READ_LO: mem_op = IDT_LO;
         READ_HI: mem_op = IDT_HI;
         default: mem_op = NONE;
      endcase
   end

   assign busy               = (state != IDLE);
   assign decode_start_int   = (state == DRAIN);
   assign flush              = (state == FLUSH);
   assign capture_bottom_eip = (state == FLUSH);  // EIP is taken while the pipe is flushed.

   // Returned words are strobed straight into the capture registers.
   assign load_eip    = (state == WAIT_LO) && mem_dp_valid;
   assign reg_load_cs = (state == WAIT_HI) && mem_dp_valid;

   assign fetch_load = (state == LOAD);
   assign int_clear  = (state == LOAD);

endmodule

/* hdl/int_target_capture.sv */
module int_target_capture (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        capture_bottom_eip,
   input  logic [31:0] current_eip,
   input  logic        load_eip,
   input  logic        reg_load_cs,
   input  logic [31:0] mem_dp_read_data,
   output logic [31:0] return_eip,
   output logic [31:0] fetch_load_address,
   output logic [15:0] reg_cs
);

   // EIP of the oldest instruction left behind by the flush.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         return_eip <= '0;
      end else if (capture_bottom_eip) begin
         return_eip <= current_eip;
      end
   end

   // Offset word of the descriptor becomes the new fetch address.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_load_address <= '0;
      end else if (load_eip) begin
         fetch_load_address <= mem_dp_read_data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reg_cs <= '0;
      end else if (reg_load_cs) begin
         reg_cs <= mem_dp_read_data[15:0];  // Selector sits in the low half.
      end
   end

endmodule

/* hdl/int_unit_top.sv */
`include "int_macros.svh"

module int_unit_top
   import int_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`INT_LINES-1:0] irq,
   input  logic [`INT_LINES-1:0] int_mask,
   input  logic [31:0]           current_eip,
   input  logic                  decode_end_int,
   input  logic                  mem_ready,
   input  logic                  mem_dp_valid,
   input  logic [31:0]           mem_dp_read_data,
   output logic                  decode_start_int,
   output logic                  flush,
   output logic                  mem_valid,
   output logic [31:0]           mem_address,
   output logic                  mem_wr_en,
   output logic [31:0]           mem_wr_data,
   output logic                  fetch_load,
   output logic [31:0]           fetch_load_address,
   output logic                  reg_load_cs,
   output logic [15:0]           reg_cs,
   output logic                  int_clear
);

   logic                  busy;
   logic                  or_int_vec;
   logic [`INT_VEC_W-1:0] vector;
   mem_op_e               mem_op;
   logic                  load_eip;
   logic                  capture_bottom_eip;
   logic [31:0]           return_eip;

   int_vector_select select_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .irq        (irq),
      .int_mask   (int_mask),
      .busy       (busy),
      .int_clear  (int_clear),
      .or_int_vec (or_int_vec),
      .vector     (vector)
   );

   int_sequencer sequencer_i (
      .clk                (clk),
      .rst_n              (rst_n),
      .or_int_vec         (or_int_vec),
      .decode_end_int     (decode_end_int),
      .mem_ready          (mem_ready),
      .mem_dp_valid       (mem_dp_valid),
      .busy               (busy),
      .decode_start_int   (decode_start_int),
      .flush              (flush),
      .capture_bottom_eip (capture_bottom_eip),
      .mem_op             (mem_op),
      .load_eip           (load_eip),
      .reg_load_cs        (reg_load_cs),
      .fetch_load         (fetch_load),
      .int_clear          (int_clear)
   );

   int_mem_port mem_port_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .mem_op      (mem_op),
      .vector      (vector),
      .return_eip  (return_eip),
      .mem_ready   (mem_ready),
      .mem_valid   (mem_valid),
      .mem_address (mem_address),
      .mem_wr_en   (mem_wr_en),
      .mem_wr_data (mem_wr_data)
   );

   int_target_capture capture_i (
      .clk                (clk),
      .rst_n              (rst_n),
      .capture_bottom_eip (capture_bottom_eip),
      .current_eip        (current_eip),
      .load_eip           (load_eip),
      .reg_load_cs        (reg_load_cs),
      .mem_dp_read_data   (mem_dp_read_data),
      .return_eip         (return_eip),
      .fetch_load_address (fetch_load_address),
      .reg_cs             (reg_cs)
   );

endmodule

/* hdl/int_vector_select.sv */
`include "int_macros.svh"

module int_vector_select (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [`INT_LINES-1:0] irq,
   input  logic [`INT_LINES-1:0] int_mask,
   input  logic                  busy,
   input  logic                  int_clear,
   output logic                  or_int_vec,
   output logic [`INT_VEC_W-1:0] vector
);

   logic [`INT_LINES-1:0] pending;
   logic [`INT_LINES-1:0] eligible;
   logic [`INT_LINES-1:0] clear_bits;
   logic [`INT_VEC_W-1:0] winner;

   assign eligible   = pending & ~int_mask;  // Masked lines stay pending.
   assign or_int_vec = |eligible;

   // Only the vector being served gets its pending bit cleared.
   always_comb begin
      clear_bits = '0;
      if (int_clear) begin
         clear_bits[vector] = 1'b1;
      end
   end

   // Scan from the top so that the lowest eligible index is the last one written.
   always_comb begin
      winner = '0;
      for (int i = `INT_LINES - 1; i >= 0; i--) begin
         if (eligible[i]) begin
            winner = `INT_VEC_W'(i);
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending <= '0;
         vector  <= '0;
      end else begin
         pending <= (pending & ~clear_bits) | irq;  // A fresh request on the taken line survives.
         if (!busy) begin
            vector <= winner;  // Frozen once the sequencer has left IDLE.
         end
      end
   end

endmodule
